//--- verilog/bpPkg.sv
package bpPkg;

    parameter int HIST_BITS = 8;

    typedef logic [31:0] addr_t; // Byte address, bit 0 always zero
    typedef logic [HIST_BITS-1:0] hist_t; // Newest outcome in LSB
    typedef logic [1:0] ctr_t; // MSB set means taken
    typedef logic tagId_t; // 0 base table, 1 tagged table

    parameter ctr_t CTR_WEAK_NT = 2'b01;
    parameter ctr_t CTR_WEAK_T = 2'b10;

    parameter tagId_t TAGE_ID_BASE = 1'b0;
    parameter tagId_t TAGE_ID_TAGGED = 1'b1;

    // Saturating step toward the outcome
    function automatic ctr_t ctrNext(ctr_t ctr, logic taken);
        ctr_t res;
        res = ctr;
        if (taken && ctr != 2'b11) begin
            res = ctr + 2'd1;
        end else if (!taken && ctr != 2'b00) begin
            res = ctr - 2'd1;
        end
        return res;
    endfunction

endpackage

//--- verilog/BranchTargetBuffer.sv
`timescale 1ns/1ps

module BranchTargetBuffer #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          clear,

    input  logic          lookupValid,
    input  bpPkg::addr_t  lookupPc,

    input  logic          updValid,
    input  bpPkg::addr_t  updPc,
    input  bpPkg::addr_t  updDst,
    input  logic          updIsJump,

    output logic          hit,
    output bpPkg::addr_t  dst,
    output logic          hitIsJump
);

    localparam int IDX_BITS = $clog2(NUM_ENTRIES);
    localparam int TAG_BITS = 30 - IDX_BITS;

    typedef logic [IDX_BITS-1:0] btbIdx_t;
    typedef logic [TAG_BITS-1:0] btbTag_t;

    logic         entryValid [NUM_ENTRIES];
    btbTag_t      entryTag [NUM_ENTRIES];
    bpPkg::addr_t entryDst [NUM_ENTRIES];
    logic         entryJump [NUM_ENTRIES];

    btbIdx_t lookupIdx;
    btbTag_t lookupTag;
    btbIdx_t updIdx;
    btbTag_t updTag;

    assign lookupIdx = lookupPc[IDX_BITS+1:2];
    assign lookupTag = lookupPc[31:IDX_BITS+2];
    assign updIdx = updPc[IDX_BITS+1:2];
    assign updTag = updPc[31:IDX_BITS+2];

    assign hit = lookupValid && entryValid[lookupIdx] && (entryTag[lookupIdx] == lookupTag);
    assign dst = entryDst[lookupIdx];
    assign hitIsJump = entryJump[lookupIdx];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entryValid[i] <= 1'b0;
            end
        end else if (updValid) begin
            entryValid[updIdx] <= 1'b1;
        end
    end

    // Payload written regardless of clear, valid bit decides
    always_ff @(posedge clk) begin
        if (updValid) begin
            entryTag[updIdx] <= updTag;
            entryDst[updIdx] <= updDst;
            entryJump[updIdx] <= updIsJump;
        end
    end

endmodule

//--- verilog/TagePredictor.sv
`timescale 1ns/1ps

module TagePredictor #(
    parameter int NUM_ENTRIES = 32
) (
    input  logic            clk,
    input  logic            rst,

    input  bpPkg::addr_t    predPc,
    input  bpPkg::hist_t    predHistory,
    output logic            predTaken,
    output bpPkg::tagId_t   predTageId,

    input  logic            writeValid,
    input  bpPkg::addr_t    writePc,
    input  bpPkg::hist_t    writeHistory,
    input  logic            writeTaken,
    input  logic            writePredTaken,
    input  bpPkg::tagId_t   writeTageId
);

    localparam int IDX_BITS = $clog2(NUM_ENTRIES);
    localparam int TAG_BITS = 8;

    typedef logic [IDX_BITS-1:0] tIdx_t;
    typedef logic [TAG_BITS-1:0] tTag_t;

    bpPkg::ctr_t baseCtr [NUM_ENTRIES];
    logic        tValid [NUM_ENTRIES];
    logic        tUseful [NUM_ENTRIES];
    tTag_t       tTag [NUM_ENTRIES];
    bpPkg::ctr_t tCtr [NUM_ENTRIES];

    // Folds the history down to index width
    function automatic tIdx_t foldHist(bpPkg::hist_t hist);
        tIdx_t folded;
        folded = '0;
        for (int i = 0; i < bpPkg::HIST_BITS; i++) begin
            folded[i % IDX_BITS] = folded[i % IDX_BITS] ^ hist[i];
        end
        return folded;
    endfunction

    tIdx_t pBaseIdx;
    tIdx_t pTagIdx;
    tTag_t pTag;
    logic  pTagHit;
    tIdx_t wBaseIdx;
    tIdx_t wTagIdx;
    tTag_t wTag;
    logic  wTagHit;

    assign pBaseIdx = predPc[IDX_BITS+1:2];
    assign pTagIdx = predPc[IDX_BITS+1:2] ^ foldHist(predHistory);
    assign pTag = predPc[IDX_BITS+2 +: TAG_BITS];
    assign pTagHit = tValid[pTagIdx] && (tTag[pTagIdx] == pTag);

    assign wBaseIdx = writePc[IDX_BITS+1:2];
    assign wTagIdx = writePc[IDX_BITS+1:2] ^ foldHist(writeHistory);
    assign wTag = writePc[IDX_BITS+2 +: TAG_BITS];
    assign wTagHit = tValid[wTagIdx] && (tTag[wTagIdx] == wTag);

    assign predTageId = pTagHit ? bpPkg::TAGE_ID_TAGGED : bpPkg::TAGE_ID_BASE;
    assign predTaken = pTagHit ? tCtr[pTagIdx][1] : baseCtr[pBaseIdx][1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                baseCtr[i] <= bpPkg::CTR_WEAK_NT;
                tCtr[i] <= bpPkg::CTR_WEAK_NT;
                tValid[i] <= 1'b0;
                tUseful[i] <= 1'b0;
            end
        end else if (writeValid) begin
            if (writeTageId == bpPkg::TAGE_ID_TAGGED) begin
                if (wTagHit) begin // Entry may have been replaced since
                    tCtr[wTagIdx] <= bpPkg::ctrNext(tCtr[wTagIdx], writeTaken);
                    tUseful[wTagIdx] <= (tCtr[wTagIdx][1] == writeTaken);
                end
            end else begin
                baseCtr[wBaseIdx] <= bpPkg::ctrNext(baseCtr[wBaseIdx], writeTaken);
                if (writeTaken != writePredTaken) begin
                    if (!tUseful[wTagIdx]) begin
                        tValid[wTagIdx] <= 1'b1;
                        tTag[wTagIdx] <= wTag;
                        tCtr[wTagIdx] <= writeTaken ? bpPkg::CTR_WEAK_T
                                                    : bpPkg::CTR_WEAK_NT;
                    end else begin
                        tUseful[wTagIdx] <= 1'b0; // Age out, retry next time
                    end
                end
            end
        end
    end

endmodule

//--- verilog/BranchPredictor.sv
`timescale 1ns/1ps

module BranchPredictor #(
    parameter int NUM_IN = 2,
    parameter int NUM_ENTRIES = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            clearICache,
    input  logic            mispredFlush,
    input  logic            redirectValid,
    input  bpPkg::hist_t    redirectHistory,

    input  logic            fetchValid,
    input  bpPkg::addr_t    fetchPc,

    input  logic            btValid [NUM_IN],
    input  bpPkg::addr_t    btPc [NUM_IN],
    input  bpPkg::addr_t    btDst [NUM_IN],
    input  logic            btIsJump [NUM_IN],

    input  logic            bpValid,
    input  bpPkg::addr_t    bpPc,
    input  logic            bpTaken,
    input  bpPkg::hist_t    bpHistory,
    input  bpPkg::tagId_t   bpTageId,
    input  logic            bpPredTaken,
    input  logic            bpIsJump,

    output logic            branchFound,
    output logic            branchTaken,
    output logic            isJump,
    output bpPkg::addr_t    branchDst,
    output bpPkg::hist_t    branchHistory,
    output bpPkg::tagId_t   predTageId
);

    bpPkg::hist_t gHistory;
    logic         tageTaken;
    logic         tageWrite;

    logic         updValid;
    bpPkg::addr_t updPc;
    bpPkg::addr_t updDst;
    logic         updIsJump;

    // Highest valid port wins
    always_comb begin
        updValid = 1'b0;
        updPc = '0;
        updDst = '0;
        updIsJump = 1'b0;
        for (int i = 0; i < NUM_IN; i++) begin
            if (btValid[i]) begin
                updValid = 1'b1;
                updPc = btPc[i];
                updDst = btDst[i];
                updIsJump = btIsJump[i];
            end
        end
    end

    assign tageWrite = bpValid && !bpIsJump && !mispredFlush;
    assign branchTaken = branchFound && (isJump || tageTaken);
    assign branchHistory = gHistory;

    BranchTargetBuffer #(.NUM_ENTRIES(NUM_ENTRIES)) btb_i (
        .clk(clk), .rst(rst), .clear(clearICache),
        .lookupValid(fetchValid), .lookupPc(fetchPc),
        .updValid(updValid), .updPc(updPc), .updDst(updDst), .updIsJump(updIsJump),
        .hit(branchFound), .dst(branchDst), .hitIsJump(isJump)
    );

    TagePredictor #(.NUM_ENTRIES(NUM_ENTRIES)) tage_i (
        .clk(clk), .rst(rst),
        .predPc(fetchPc), .predHistory(gHistory),
        .predTaken(tageTaken), .predTageId(predTageId),
        .writeValid(tageWrite), .writePc(bpPc), .writeHistory(bpHistory),
        .writeTaken(bpTaken), .writePredTaken(bpPredTaken), .writeTageId(bpTageId)
    );

    // Speculative history, redirect restores it
    always_ff @(posedge clk) begin
        if (rst) begin
            gHistory <= '0;
        end else if (redirectValid) begin
            gHistory <= redirectHistory;
        end else if (branchFound && !isJump) begin
            gHistory <= {gHistory[bpPkg::HIST_BITS-2:0], branchTaken};
        end
    end

endmodule

//--- verilog/FetchStage.sv
`timescale 1ns/1ps

module FetchStage #(
    parameter bpPkg::addr_t RESET_PC = 32'h8000_0000
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          redirectValid,
    input  bpPkg::addr_t  redirectPc,
    input  logic          branchTaken,
    input  bpPkg::addr_t  branchDst,
    output logic          fetchValid,
    output bpPkg::addr_t  fetchPc
);

    bpPkg::addr_t nextPc;

    always_comb begin
        if (redirectValid) begin
            nextPc = redirectPc;
        end else if (branchTaken) begin
            nextPc = branchDst;
        end else if (fetchValid) begin
            nextPc = fetchPc + 32'd4;
        end else begin
            nextPc = fetchPc; // First valid cycle presents RESET_PC
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchValid <= 1'b0;
            fetchPc <= RESET_PC;
        end else begin
            fetchValid <= 1'b1;
            fetchPc <= nextPc;
        end
    end

endmodule

//--- verilog/FrontEnd.sv
`timescale 1ns/1ps

module FrontEnd #(
    parameter int NUM_IN = 2,
    parameter int NUM_ENTRIES = 32,
    parameter bpPkg::addr_t RESET_PC = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            rst,

    input  logic            redirectValid,
    input  bpPkg::addr_t    redirectPc,
    input  bpPkg::hist_t    redirectHistory,
    input  logic            mispredFlush,
    input  logic            clearICache,

    input  logic            btValid [NUM_IN],
    input  bpPkg::addr_t    btPc [NUM_IN],
    input  bpPkg::addr_t    btDst [NUM_IN],
    input  logic            btIsJump [NUM_IN],

    input  logic            bpValid,
    input  bpPkg::addr_t    bpPc,
    input  logic            bpTaken,
    input  bpPkg::hist_t    bpHistory,
    input  bpPkg::tagId_t   bpTageId,
    input  logic            bpPredTaken,
    input  logic            bpIsJump,

    output logic            fetchValid,
    output bpPkg::addr_t    fetchPc,
    output logic            branchFound,
    output logic            branchTaken,
    output logic            isJump,
    output bpPkg::addr_t    branchDst,
    output bpPkg::hist_t    branchHistory,
    output bpPkg::tagId_t   predTageId
);

    FetchStage #(.RESET_PC(RESET_PC)) fetch_i (
        .clk(clk), .rst(rst),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .branchTaken(branchTaken), .branchDst(branchDst),
        .fetchValid(fetchValid), .fetchPc(fetchPc)
    );

    BranchPredictor #(.NUM_IN(NUM_IN), .NUM_ENTRIES(NUM_ENTRIES)) bp_i (
        .clk(clk), .rst(rst), .clearICache(clearICache), .mispredFlush(mispredFlush),
        .redirectValid(redirectValid), .redirectHistory(redirectHistory),
        .fetchValid(fetchValid), .fetchPc(fetchPc),
        .btValid(btValid), .btPc(btPc), .btDst(btDst), .btIsJump(btIsJump),
        .bpValid(bpValid), .bpPc(bpPc), .bpTaken(bpTaken), .bpHistory(bpHistory),
        .bpTageId(bpTageId), .bpPredTaken(bpPredTaken), .bpIsJump(bpIsJump),
        .branchFound(branchFound), .branchTaken(branchTaken), .isJump(isJump),
        .branchDst(branchDst), .branchHistory(branchHistory), .predTageId(predTageId)
    );

endmodule

//--- test/FrontEnd_assert.sv
`timescale 1ns/1ps

module FrontEnd_assert (
    input logic         clk,
    input logic         rst,
    input logic         fetchValid,
    input logic         branchTaken,
    input bpPkg::addr_t branchDst,
    input logic         redirectValid,
    input bpPkg::addr_t redirectPc,
    input bpPkg::addr_t fetchPc
);

    validLowInReset: assert property (@(posedge clk) rst |=> !fetchValid)
        else $error("fetchValid high after a reset cycle");

    takenSteersFetch: assert property (@(posedge clk) disable iff (rst)
        branchTaken && !redirectValid |=> fetchPc == $past(branchDst))
        else $error("fetchPc did not follow a taken prediction");

    redirectLoadsPc: assert property (@(posedge clk) disable iff (rst)
        redirectValid |=> fetchPc == $past(redirectPc))
        else $error("fetchPc did not follow redirectPc");

endmodule

bind FrontEnd FrontEnd_assert assert_i (.*);

//--- test/FrontEnd_tb.sv
`timescale 1ns/1ps

module FrontEnd_tb;

    localparam int NUM_IN = 2;
    localparam int NUM_ENTRIES = 32;
    localparam bpPkg::addr_t RESET_PC = 32'h8000_0000;
    localparam int N_STEPS = 16;
    localparam int K_BT = 0, K_LOOK = 1, K_COMMIT = 2, K_FLUSH = 3, K_MISS = 4;
    localparam int K_OVER = 5, K_CLEAR = 6;

    typedef struct {
        int            kind;
        string         name;
        bpPkg::addr_t  pc;
        bpPkg::addr_t  dst;
        logic          flag; // Jump bit or committed outcome
        bpPkg::hist_t  hist;
        logic          expTaken;
        bpPkg::tagId_t expTageId;
    } step_t;

    logic clk, rst, redirectValid, mispredFlush, clearICache;
    bpPkg::addr_t redirectPc, bpPc, fetchPc, branchDst;
    bpPkg::hist_t redirectHistory, bpHistory, branchHistory;
    logic btValid [NUM_IN];
    bpPkg::addr_t btPc [NUM_IN];
    bpPkg::addr_t btDst [NUM_IN];
    logic btIsJump [NUM_IN];
    logic bpValid, bpTaken, bpPredTaken, bpIsJump;
    bpPkg::tagId_t bpTageId, predTageId;
    logic fetchValid, branchFound, branchTaken, isJump;

    step_t steps [N_STEPS];
    logic mValid [NUM_ENTRIES]; // Reference BTB
    bpPkg::addr_t mPc [NUM_ENTRIES];
    bpPkg::addr_t mDst [NUM_ENTRIES];
    logic mJump [NUM_ENTRIES];
    logic [31:0] seed = 32'he215_8a66;
    int errors = 0;
    int checks = 0;

    FrontEnd #(.NUM_IN(NUM_IN), .NUM_ENTRIES(NUM_ENTRIES), .RESET_PC(RESET_PC)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int modelIdx(bpPkg::addr_t pc);
        return int'(pc[31:2]) % NUM_ENTRIES;
    endfunction

    task automatic checkAddr(string name, bpPkg::addr_t exp, bpPkg::addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkHist(string name, bpPkg::hist_t exp, bpPkg::hist_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkTag(string name, bpPkg::tagId_t exp, bpPkg::tagId_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Redirect to pc, check the lookup, then the next PC and history
    task automatic lookAt(string name, bpPkg::addr_t pc, bpPkg::hist_t h, logic dirKnown,
                          logic dirTaken, bpPkg::tagId_t expTag, logic over,
                          bpPkg::addr_t overPc);
        int idx;
        logic expFound;
        logic expJump;
        logic expTk;
        bpPkg::addr_t expNext;
        bpPkg::hist_t expHist;
        idx = modelIdx(pc);
        expFound = mValid[idx] && (mPc[idx][31:2] == pc[31:2]);
        expJump = expFound && mJump[idx];
        expTk = expFound && (expJump || dirTaken);
        @(posedge clk);
        redirectValid <= 1'b1;
        redirectPc <= pc;
        redirectHistory <= h;
        @(posedge clk);
        if (over) begin
            redirectPc <= overPc; // Redirect in the lookup cycle itself
            redirectHistory <= ~h;
        end else begin
            redirectValid <= 1'b0;
        end
        @(negedge clk);
        checkAddr({name, " pc"}, pc, fetchPc);
        checkHist({name, " history"}, h, branchHistory);
        checkBit({name, " found"}, expFound, branchFound);
        if (!expFound || !dirKnown) begin
            return;
        end
        checkAddr({name, " dst"}, mDst[idx], branchDst);
        checkBit({name, " jump"}, expJump, isJump);
        checkBit({name, " taken"}, expTk, branchTaken);
        if (!expJump) begin
            checkTag({name, " provider"}, expTag, predTageId);
        end
        expNext = over ? overPc : (expTk ? mDst[idx] : pc + 32'd4);
        expHist = over ? ~h : (expJump ? h : {h[bpPkg::HIST_BITS-2:0], expTk});
        @(posedge clk);
        redirectValid <= 1'b0;
        @(negedge clk);
        checkAddr({name, " next pc"}, expNext, fetchPc);
        checkHist({name, " next history"}, expHist, branchHistory);
    endtask

    task automatic applyStep(step_t s);
        int idx;
        bpPkg::addr_t idxMask;
        bpPkg::addr_t missPc;
        case (s.kind)
            K_BT: begin
                @(posedge clk);
                btValid[0] <= 1'b1; // Loses to the higher port
                btPc[0] <= s.pc ^ 32'h1000_0000;
                btDst[0] <= s.dst ^ 32'h0000_0100;
                btIsJump[0] <= ~s.flag;
                btValid[NUM_IN-1] <= 1'b1;
                btPc[NUM_IN-1] <= s.pc;
                btDst[NUM_IN-1] <= s.dst;
                btIsJump[NUM_IN-1] <= s.flag;
                @(posedge clk);
                btValid[0] <= 1'b0;
                btValid[NUM_IN-1] <= 1'b0;
                idx = modelIdx(s.pc);
                mValid[idx] = 1'b1;
                mPc[idx] = s.pc;
                mDst[idx] = s.dst;
                mJump[idx] = s.flag;
            end
            K_COMMIT, K_FLUSH: begin
                @(posedge clk);
                bpValid <= 1'b1;
                bpPc <= s.pc;
                bpTaken <= s.flag;
                bpHistory <= s.hist;
                bpTageId <= bpPkg::TAGE_ID_BASE;
                bpPredTaken <= 1'b0;
                mispredFlush <= (s.kind == K_FLUSH);
                @(posedge clk);
                bpValid <= 1'b0;
                mispredFlush <= 1'b0;
            end
            K_CLEAR: begin
                @(posedge clk);
                clearICache <= 1'b1;
                @(posedge clk);
                clearICache <= 1'b0;
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    mValid[i] = 1'b0;
                end
            end
            K_MISS: begin
                idxMask = bpPkg::addr_t'(NUM_ENTRIES - 1) << 2;
                for (int i = 0; i < 8; i++) begin
                    seed = lcgNext(seed);
                    missPc = (seed & ~idxMask & ~32'h3) | (s.pc & idxMask); // Same index, other tag
                    lookAt(s.name, missPc, seed[9:2], 1'b0, 1'b0,
                           bpPkg::TAGE_ID_BASE, 1'b0, '0);
                end
            end
            default: begin
                lookAt(s.name, s.pc, s.hist, 1'b1, s.expTaken, s.expTageId,
                       s.kind == K_OVER, s.dst);
            end
        endcase
    endtask

    initial begin
        steps[0] = '{K_BT, "jump update", 32'h8000_0100, 32'h8000_0200, 1'b1, 8'h00, 1'b1, 1'b0};
        steps[1] = '{K_LOOK, "jump hit", 32'h8000_0100, 32'h0, 1'b0, 8'h00, 1'b1, 1'b0};
        steps[2] = '{K_BT, "cond update", 32'h8000_0140, 32'h8000_0300, 1'b0, 8'h00, 1'b0, 1'b0};
        steps[3] = '{K_LOOK, "cond reset", 32'h8000_0140, 32'h0, 1'b0, 8'h5a, 1'b0, 1'b0};
        steps[4] = '{K_COMMIT, "train", 32'h8000_0140, 32'h0, 1'b1, 8'h00, 1'b0, 1'b0};
        steps[5] = '{K_LOOK, "tagged hit", 32'h8000_0140, 32'h0, 1'b0, 8'h00, 1'b1, 1'b1};
        steps[6] = '{K_LOOK, "base taken", 32'h8000_0140, 32'h0, 1'b0, 8'h01, 1'b1, 1'b0};
        steps[7] = '{K_BT, "flush update", 32'h8000_0188, 32'h8000_0400, 1'b0, 8'h00, 1'b0, 1'b0};
        steps[8] = '{K_FLUSH, "flushed", 32'h8000_0188, 32'h0, 1'b1, 8'h00, 1'b0, 1'b0};
        steps[9] = '{K_LOOK, "after flush", 32'h8000_0188, 32'h0, 1'b0, 8'h00, 1'b0, 1'b0};
        steps[10] = '{K_MISS, "random miss", 32'h8000_0140, 32'h0, 1'b0, 8'h00, 1'b0, 1'b0};
        steps[11] = '{K_OVER, "override", 32'h8000_0140, 32'h8000_0800, 1'b0, 8'h33, 1'b1, 1'b0};
        steps[12] = '{K_CLEAR, "clear", 32'h0, 32'h0, 1'b0, 8'h00, 1'b0, 1'b0};
        steps[13] = '{K_LOOK, "cleared jump", 32'h8000_0100, 32'h0, 1'b0, 8'h00, 1'b0, 1'b0};
        steps[14] = '{K_LOOK, "cleared cond", 32'h8000_0140, 32'h0, 1'b0, 8'h00, 1'b0, 1'b0};
        steps[15] = '{K_LOOK, "cleared third", 32'h8000_0188, 32'h0, 1'b0, 8'h00, 1'b0, 1'b0};
    end

    initial begin
        rst = 1'b1;
        redirectValid = 1'b0;
        redirectPc = '0;
        redirectHistory = '0;
        mispredFlush = 1'b0;
        clearICache = 1'b0;
        bpValid = 1'b0;
        bpPc = '0;
        bpTaken = 1'b0;
        bpHistory = '0;
        bpTageId = bpPkg::TAGE_ID_BASE;
        bpPredTaken = 1'b0;
        bpIsJump = 1'b0;
        for (int i = 0; i < NUM_IN; i++) begin
            btValid[i] = 1'b0;
            btPc[i] = '0;
            btDst[i] = '0;
            btIsJump[i] = 1'b0;
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            mValid[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkBit("valid in reset", 1'b0, fetchValid);
        @(negedge clk);
        checkBit("valid after reset", 1'b1, fetchValid); // First edge after reset
        checkAddr("reset pc", RESET_PC, fetchPc);
        checkBit("reset found", 1'b0, branchFound);
        for (int i = 1; i <= 3; i++) begin
            @(negedge clk);
            checkAddr("sequential pc", RESET_PC + 32'(4 * i), fetchPc);
        end
        for (int i = 0; i < N_STEPS; i++) begin
            applyStep(steps[i]);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Each step gets 20 cycles, plus reset
    initial begin
        repeat (N_STEPS * 20 + 20) @(posedge clk);
        $display("Timeout: the run did not finish in the allowed number of cycles");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- project.f
verilog/bpPkg.sv
verilog/BranchTargetBuffer.sv
verilog/TagePredictor.sv
verilog/BranchPredictor.sv
verilog/FetchStage.sv
verilog/FrontEnd.sv
test/FrontEnd_assert.sv
test/FrontEnd_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the FrontEnd testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module FrontEnd_tb -f project.f -o simv
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
